// ==== source/ntt_pkg.sv ====
package ntt_pkg;

    // datapath widths
    // default coefficient width, enough for the Kyber modulus
    localparam int COEF_W = 12;

    // default prime modulus
    localparam int unsigned Q_DEFAULT = 3329;

    // write-back address tag
    localparam int ADDR_W = 8;

    // pipeline latencies in clock cycles
    // product registered, then reduced
    localparam int MUL_LATENCY = 2;

    // input register, multiplier, output register
    localparam int LANE_LATENCY = 1 + MUL_LATENCY + 1;

    // one register for the combined beat
    localparam int MERGE_LATENCY = 1;

endpackage

// ==== source/mod_mult.sv ====
`timescale 1ns/1ns

module mod_mult #(
    parameter int          COEF_W = ntt_pkg::COEF_W,
    parameter int unsigned Q      = ntt_pkg::Q_DEFAULT
) (
    input  logic              clk,
    input  logic [COEF_W-1:0] a_i,
    input  logic [COEF_W-1:0] b_i,
    output logic [COEF_W-1:0] p_o
);

    localparam int PROD_W = 2 * COEF_W;

    // modulus at product width so the remainder stays PROD_W wide
    localparam logic [PROD_W-1:0] Q_PROD = PROD_W'(Q);

    logic [PROD_W-1:0] prod_r;
    logic [COEF_W-1:0] p_r;

    // stage 1: full product, no reduction yet
    always_ff @(posedge clk) begin
        prod_r <= a_i * b_i;
    end

    // stage 2: reduce by constant modulus
    // remainder is below Q, so it fits in COEF_W bits
    always_ff @(posedge clk) begin
        p_r <= COEF_W'(prod_r % Q_PROD);
    end

    assign p_o = p_r;

endmodule

// ==== source/butterfly_lane.sv ====
`timescale 1ns/1ns

module butterfly_lane #(
    parameter int          COEF_W = ntt_pkg::COEF_W,
    parameter int unsigned Q      = ntt_pkg::Q_DEFAULT
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid_i,
    input  logic              is_intt_i,
    input  logic [COEF_W-1:0] a_i,
    input  logic [COEF_W-1:0] b_i,
    input  logic [COEF_W-1:0] w_i,
    output logic              valid_o,
    output logic [COEF_W-1:0] x_o,
    output logic [COEF_W-1:0] y_o
);

    localparam int DLY = ntt_pkg::MUL_LATENCY;
    localparam logic [COEF_W:0] Q_EXT = (COEF_W + 1)'(Q);

    // operands are below Q, so one conditional subtract is enough
    function automatic logic [COEF_W-1:0] add_mod(input logic [COEF_W-1:0] a,
                                                  input logic [COEF_W-1:0] b);
        logic [COEF_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= Q_EXT) s = s - Q_EXT;
        return s[COEF_W-1:0];
    endfunction

    function automatic logic [COEF_W-1:0] sub_mod(input logic [COEF_W-1:0] a,
                                                  input logic [COEF_W-1:0] b);
        logic [COEF_W:0] d;
        d = {1'b0, a} - {1'b0, b};
        // borrow wraps the extra bit, adding Q brings it back in range
        if (a < b) d = d + Q_EXT;
        return d[COEF_W-1:0];
    endfunction

    logic              valid_r, intt_r;
    logic [COEF_W-1:0] a_r, b_r, w_r;
    logic [COEF_W-1:0] mul_op, bypass, prod;
    logic [COEF_W-1:0] byp_q [DLY];
    logic [DLY-1:0]    vld_q, intt_q;
    logic              valid_out_r;
    logic [COEF_W-1:0] x_r, y_r;

    // stage 1: input register
    always_ff @(posedge clk) begin
        a_r    <= a_i;
        b_r    <= b_i;
        w_r    <= w_i;
        intt_r <= is_intt_i;
        if (reset) valid_r <= 1'b0;
        else       valid_r <= valid_i;
    end

    // forward multiplies b, inverse multiplies a - b
    assign mul_op = intt_r ? sub_mod(a_r, b_r) : b_r;
    assign bypass = intt_r ? add_mod(a_r, b_r) : a_r;

    mod_mult #(
        .COEF_W(COEF_W),
        .Q     (Q)
    ) u_mul (
        .clk(clk),
        .a_i(mul_op),
        .b_i(w_r),
        .p_o(prod)
    );

    // side delay matching the multiplier
    always_ff @(posedge clk) begin
        byp_q[0]  <= bypass;
        intt_q[0] <= intt_r;
        for (int k = 1; k < DLY; k++) begin
            byp_q[k]  <= byp_q[k-1];
            intt_q[k] <= intt_q[k-1];
        end
        if (reset) vld_q <= '0;
        else       vld_q <= {vld_q[DLY-2:0], valid_r};
    end

    // output stage
    always_ff @(posedge clk) begin
        if (intt_q[DLY-1]) begin
            x_r <= byp_q[DLY-1];
            y_r <= prod;
        end else begin
            x_r <= add_mod(byp_q[DLY-1], prod);
            y_r <= sub_mod(byp_q[DLY-1], prod);
        end
        if (reset) valid_out_r <= 1'b0;
        else       valid_out_r <= vld_q[DLY-1];
    end

    assign valid_o = valid_out_r;
    assign x_o     = x_r;
    assign y_o     = y_r;

endmodule

// ==== source/writeback_merge.sv ====
`timescale 1ns/1ns

module writeback_merge #(
    parameter int COEF_W = ntt_pkg::COEF_W,
    parameter int ADDR_W = ntt_pkg::ADDR_W
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid_i,
    input  logic [ADDR_W-1:0] tag_i,
    input  logic              lane0_valid_i,
    input  logic [COEF_W-1:0] lane0_x_i,
    input  logic [COEF_W-1:0] lane0_y_i,
    input  logic [COEF_W-1:0] lane1_x_i,
    input  logic [COEF_W-1:0] lane1_y_i,
    output logic              valid_o,
    output logic [ADDR_W-1:0] tag_o,
    output logic [COEF_W-1:0] y0_o,
    output logic [COEF_W-1:0] y1_o,
    output logic [COEF_W-1:0] y2_o,
    output logic [COEF_W-1:0] y3_o
);

    localparam int DEPTH = ntt_pkg::LANE_LATENCY;

    logic [ADDR_W-1:0] tag_q [DEPTH];
    logic              valid_r;
    logic [ADDR_W-1:0] tag_r;
    logic [COEF_W-1:0] y0_r, y1_r, y2_r, y3_r;

    // tag delay line, same depth as a lane
    // idle slots carry a zero tag
    always_ff @(posedge clk) begin
        tag_q[0] <= valid_i ? tag_i : '0;
        for (int k = 1; k < DEPTH; k++) begin
            tag_q[k] <= tag_q[k-1];
        end
    end

    // lanes run in lockstep, lane 0 strobe stands for both
    always_ff @(posedge clk) begin
        if (lane0_valid_i) begin
            tag_r <= tag_q[DEPTH-1];
            y0_r  <= lane0_x_i;
            y1_r  <= lane0_y_i;
            y2_r  <= lane1_x_i;
            y3_r  <= lane1_y_i;
        end
        if (reset) valid_r <= 1'b0;
        else       valid_r <= lane0_valid_i;
    end

    assign valid_o = valid_r;
    assign tag_o   = tag_r;
    assign y0_o    = y0_r;
    assign y1_o    = y1_r;
    assign y2_o    = y2_r;
    assign y3_o    = y3_r;

endmodule

// ==== source/ntt_butterfly_top.sv ====
`timescale 1ns/1ns

module ntt_butterfly_top #(
    parameter int          COEF_W = ntt_pkg::COEF_W,
    parameter int unsigned Q      = ntt_pkg::Q_DEFAULT,
    parameter int          ADDR_W = ntt_pkg::ADDR_W
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid_i,
    input  logic              is_intt_i,
    input  logic [ADDR_W-1:0] tag_i,
    input  logic [COEF_W-1:0] a0_i,
    input  logic [COEF_W-1:0] b0_i,
    input  logic [COEF_W-1:0] w0_i,
    input  logic [COEF_W-1:0] a1_i,
    input  logic [COEF_W-1:0] b1_i,
    input  logic [COEF_W-1:0] w1_i,
    output logic              valid_o,
    output logic [ADDR_W-1:0] tag_o,
    output logic [COEF_W-1:0] y0_o,
    output logic [COEF_W-1:0] y1_o,
    output logic [COEF_W-1:0] y2_o,
    output logic [COEF_W-1:0] y3_o
);

    logic              lane0_valid;
    logic [COEF_W-1:0] lane0_x, lane0_y;
    logic [COEF_W-1:0] lane1_x, lane1_y;

    // first coefficient pair
    butterfly_lane #(
        .COEF_W(COEF_W),
        .Q     (Q)
    ) lane0 (
        .clk      (clk),
        .reset    (reset),
        .valid_i  (valid_i),
        .is_intt_i(is_intt_i),
        .a_i      (a0_i),
        .b_i      (b0_i),
        .w_i      (w0_i),
        .valid_o  (lane0_valid),
        .x_o      (lane0_x),
        .y_o      (lane0_y)
    );

    // second pair; its strobe matches lane 0 and is not needed
    butterfly_lane #(
        .COEF_W(COEF_W),
        .Q     (Q)
    ) lane1 (
        .clk      (clk),
        .reset    (reset),
        .valid_i  (valid_i),
        .is_intt_i(is_intt_i),
        .a_i      (a1_i),
        .b_i      (b1_i),
        .w_i      (w1_i),
        .valid_o  (),
        .x_o      (lane1_x),
        .y_o      (lane1_y)
    );

    writeback_merge #(
        .COEF_W(COEF_W),
        .ADDR_W(ADDR_W)
    ) merge (
        .clk          (clk),
        .reset        (reset),
        .valid_i      (valid_i),
        .tag_i        (tag_i),
        .lane0_valid_i(lane0_valid),
        .lane0_x_i    (lane0_x),
        .lane0_y_i    (lane0_y),
        .lane1_x_i    (lane1_x),
        .lane1_y_i    (lane1_y),
        .valid_o      (valid_o),
        .tag_o        (tag_o),
        .y0_o         (y0_o),
        .y1_o         (y1_o),
        .y2_o         (y2_o),
        .y3_o         (y3_o)
    );

endmodule

// ==== tests/ntt_asserts.sv ====
`timescale 1ns/1ns

module ntt_asserts #(
    parameter int          COEF_W = ntt_pkg::COEF_W,
    parameter int unsigned Q      = ntt_pkg::Q_DEFAULT
) (
    input logic              clk,
    input logic              reset,
    input logic              valid_i,
    input logic              valid_o,
    input logic [COEF_W-1:0] y0_o,
    input logic [COEF_W-1:0] y1_o,
    input logic [COEF_W-1:0] y2_o,
    input logic [COEF_W-1:0] y3_o
);

    localparam int TOTAL = ntt_pkg::LANE_LATENCY + ntt_pkg::MERGE_LATENCY;
    localparam logic [COEF_W-1:0] Q_C = COEF_W'(Q);

    // every strobe leaves after the fixed latency
    strobe_to_beat: assert property (@(posedge clk) disable iff (reset)
        valid_i |-> ##TOTAL valid_o)
        else $error("write-back beat missing %0d cycles after strobe", TOTAL);

    // and no beat without a strobe
    beat_from_strobe: assert property (@(posedge clk) disable iff (reset)
        valid_o |-> $past(valid_i, TOTAL))
        else $error("write-back beat without a matching strobe");

    results_below_q: assert property (@(posedge clk) disable iff (reset)
        valid_o |-> (y0_o < Q_C && y1_o < Q_C && y2_o < Q_C && y3_o < Q_C))
        else $error("write-back value not reduced below modulus");

    quiet_after_reset: assert property (@(posedge clk) reset |=> !valid_o)
        else $error("valid_o high in the cycle after reset");

endmodule

bind ntt_butterfly_top ntt_asserts #(
    .COEF_W(COEF_W),
    .Q     (Q)
) asserts_i (
    .clk    (clk),
    .reset  (reset),
    .valid_i(valid_i),
    .valid_o(valid_o),
    .y0_o   (y0_o),
    .y1_o   (y1_o),
    .y2_o   (y2_o),
    .y3_o   (y3_o)
);

// ==== tests/ntt_tb.sv ====
`timescale 1ns/1ns

module ntt_tb;

    localparam int          COEF_W     = ntt_pkg::COEF_W;
    localparam int          ADDR_W     = ntt_pkg::ADDR_W;
    localparam int unsigned Q          = ntt_pkg::Q_DEFAULT;
    localparam int          CLK_PERIOD = 40;

    // test sizes
    localparam int FWD_N    = 9;
    localparam int INV_N    = 9;
    localparam int RAND_N   = 200;
    localparam int SPARSE_N = 50;
    localparam int MAX_GAP  = 4;
    localparam int RT_PAIRS = 8;
    localparam int N_TESTS  = 5;
    // round trip sends one item and waits for its beat
    localparam int RT_ITEM_CYCLES = 3 + ntt_pkg::LANE_LATENCY + ntt_pkg::MERGE_LATENCY;
    localparam int WATCHDOG_CYCLES = 2 + FWD_N + INV_N + RAND_N + SPARSE_N * (MAX_GAP + 1)
                                   + 2 * RT_PAIRS * RT_ITEM_CYCLES + 20 * N_TESTS;

    typedef struct packed {
        logic              intt;
        logic [ADDR_W-1:0] tag;
        logic [COEF_W-1:0] a0, b0, w0, a1, b1, w1;
    } item_t;

    logic              clk, reset, valid_i, is_intt_i;
    logic [ADDR_W-1:0] tag_i;
    logic [COEF_W-1:0] a0_i, b0_i, w0_i, a1_i, b1_i, w1_i;
    logic              valid_o;
    logic [ADDR_W-1:0] tag_o;
    logic [COEF_W-1:0] y0_o, y1_o, y2_o, y3_o;

    item_t       exp_q[$];
    logic [31:0] rng_state = 32'hae40_aa43;
    string       cur_test = "reset";
    int          items_sent, beats_seen, errors, test_items, test_errors;

    // most recent write-back beat as the DUT produced it
    logic [4*COEF_W-1:0] last_beat;

    ntt_butterfly_top #(.COEF_W(COEF_W), .Q(Q), .ADDR_W(ADDR_W)) uut (
        .clk(clk), .reset(reset), .valid_i(valid_i), .is_intt_i(is_intt_i), .tag_i(tag_i),
        .a0_i(a0_i), .b0_i(b0_i), .w0_i(w0_i), .a1_i(a1_i), .b1_i(b1_i), .w1_i(w1_i),
        .valid_o(valid_o), .tag_o(tag_o),
        .y0_o(y0_o), .y1_o(y1_o), .y2_o(y2_o), .y3_o(y3_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng_state = xorshift(rng_state);
        return rng_state % n;
    endfunction

    // plain modular arithmetic on 32-bit values
    function automatic int unsigned mod_add(input int unsigned a, input int unsigned b);
        return (a + b) % Q;
    endfunction

    function automatic int unsigned mod_sub(input int unsigned a, input int unsigned b);
        return (a + Q - b) % Q;
    endfunction

    function automatic int unsigned mod_mul(input int unsigned a, input int unsigned b);
        return (a * b) % Q;
    endfunction

    // w^(Q-2) is the inverse of w for prime Q
    function automatic int unsigned inverse_mod(input int unsigned w);
        int unsigned r, base, e;
        r = 1;
        base = w;
        e = Q - 2;
        while (e != 0) begin
            if (e[0]) r = mod_mul(r, base);
            base = mod_mul(base, base);
            e = e >> 1;
        end
        return r;
    endfunction

    // Cooley-Tukey forward, Gentleman-Sande inverse
    function automatic void butterfly(input logic intt, input int unsigned a, b, w,
                                      output int unsigned x, output int unsigned y);
        if (intt) begin
            x = mod_add(a, b);
            y = mod_mul(mod_sub(a, b), w);
        end else begin
            x = mod_add(a, mod_mul(w, b));
            y = mod_sub(a, mod_mul(w, b));
        end
    endfunction

    function automatic logic [4*COEF_W-1:0] butterfly_ref(input item_t it);
        int unsigned x0, y0, x1, y1;
        butterfly(it.intt, 32'(it.a0), 32'(it.b0), 32'(it.w0), x0, y0);
        butterfly(it.intt, 32'(it.a1), 32'(it.b1), 32'(it.w1), x1, y1);
        return {COEF_W'(x0), COEF_W'(y0), COEF_W'(x1), COEF_W'(y1)};
    endfunction

    function automatic int unsigned field(input logic [4*COEF_W-1:0] v, input int idx);
        return 32'(v[(3 - idx) * COEF_W +: COEF_W]);
    endfunction

    function automatic item_t random_item(input logic intt);
        item_t it;
        it.intt = intt;
        it.tag  = '0;
        it.a0 = COEF_W'(rand_below(Q));
        it.b0 = COEF_W'(rand_below(Q));
        it.w0 = COEF_W'(rand_below(Q));
        it.a1 = COEF_W'(rand_below(Q));
        it.b1 = COEF_W'(rand_below(Q));
        it.w1 = COEF_W'(rand_below(Q));
        return it;
    endfunction

    task automatic check_value(input string what, input int unsigned exp_v,
                               input int unsigned act_v);
        assert (exp_v == act_v) else begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, exp_v, act_v);
            errors++;
            test_errors++;
        end
    endtask

    // tag is the running item count, so order shows up in the tag check
    task automatic send_item(input item_t it);
        @(posedge clk);
        #2;
        it.tag    = ADDR_W'(items_sent);
        valid_i   = 1'b1;
        is_intt_i = it.intt;
        tag_i     = it.tag;
        {a0_i, b0_i, w0_i} = {it.a0, it.b0, it.w0};
        {a1_i, b1_i, w1_i} = {it.a1, it.b1, it.w1};
        exp_q.push_back(it);
        items_sent++;
        test_items++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        valid_i = 1'b0;
    endtask

    // single strobe, then wait until its beat has been compared
    task automatic send_and_drain(input item_t it);
        send_item(it);
        idle_cycle();
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_items  = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        idle_cycle();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("%s done: %0d items, %0d errors", cur_test, test_items, test_errors);
    endtask

    task automatic run_corners(input logic intt, input string name);
        int unsigned ops[3];
        item_t it;
        ops = '{0, 1, Q - 1};
        start_test(name);
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                it = '0;
                it.intt = intt;
                it.a0 = COEF_W'(ops[i]);
                it.b0 = COEF_W'(ops[j]);
                it.a1 = COEF_W'(ops[j]);
                it.b1 = COEF_W'(ops[i]);
                it.w0 = COEF_W'(1);
                it.w1 = COEF_W'(1);
                send_item(it);
            end
        end
        finish_test();
    endtask

    task automatic run_round_trip();
        item_t fwd, inv;
        start_test("round_trip");
        for (int k = 0; k < RT_PAIRS; k++) begin
            fwd = random_item(1'b0);
            fwd.w0 = COEF_W'(1 + rand_below(Q - 1));
            fwd.w1 = COEF_W'(1 + rand_below(Q - 1));
            send_and_drain(fwd);
            // inverse pass runs on the forward beat the DUT returned
            inv = '0;
            inv.intt = 1'b1;
            inv.a0 = COEF_W'(field(last_beat, 0));
            inv.b0 = COEF_W'(field(last_beat, 1));
            inv.a1 = COEF_W'(field(last_beat, 2));
            inv.b1 = COEF_W'(field(last_beat, 3));
            inv.w0 = COEF_W'(inverse_mod(32'(fwd.w0)));
            inv.w1 = COEF_W'(inverse_mod(32'(fwd.w1)));
            send_and_drain(inv);
            // inverse of a forward pass doubles the original pair
            check_value("2*a0", mod_add(32'(fwd.a0), 32'(fwd.a0)), field(last_beat, 0));
            check_value("2*b0", mod_add(32'(fwd.b0), 32'(fwd.b0)), field(last_beat, 1));
            check_value("2*a1", mod_add(32'(fwd.a1), 32'(fwd.a1)), field(last_beat, 2));
            check_value("2*b1", mod_add(32'(fwd.b1), 32'(fwd.b1)), field(last_beat, 3));
        end
        finish_test();
    endtask

    // outputs sampled mid-cycle, away from the active edge
    always @(negedge clk) begin : compare_beats
        item_t it;
        logic [4*COEF_W-1:0] exp_v;
        if (valid_o) begin
            beats_seen++;
            last_beat = {y0_o, y1_o, y2_o, y3_o};
            assert (exp_q.size() != 0) else begin
                $display("%s: write-back beat arrived with no item outstanding", cur_test);
                errors++;
                test_errors++;
            end
            if (exp_q.size() != 0) begin
                it = exp_q.pop_front();
                exp_v = butterfly_ref(it);
                check_value("tag", 32'(it.tag), 32'(tag_o));
                check_value("y0", field(exp_v, 0), 32'(y0_o));
                check_value("y1", field(exp_v, 1), 32'(y1_o));
                check_value("y2", field(exp_v, 2), 32'(y2_o));
                check_value("y3", field(exp_v, 3), 32'(y3_o));
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        valid_i = 1'b0;
        is_intt_i = 1'b0;
        tag_i = '0;
        {a0_i, b0_i, w0_i, a1_i, b1_i, w1_i} = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        run_corners(1'b0, "forward_corners");
        run_corners(1'b1, "inverse_corners");

        start_test("random_back_to_back");
        for (int k = 0; k < RAND_N; k++) send_item(random_item(rand_below(2) == 1));
        finish_test();

        start_test("sparse_strobes");
        for (int k = 0; k < SPARSE_N; k++) begin
            send_item(random_item(rand_below(2) == 1));
            repeat (rand_below(MAX_GAP + 1)) idle_cycle();
        end
        finish_test();

        run_round_trip();

        assert (exp_q.size() == 0) else begin
            $display("%0d items never came out of the DUT", exp_q.size());
            errors++;
        end
        assert (beats_seen == items_sent) else begin
            $display("beat count %0d does not match item count %0d", beats_seen, items_sent);
            errors++;
        end
        $display("%0d tests, %0d items, %0d beats, %0d errors",
                 N_TESTS, items_sent, beats_seen, errors);
        if (errors == 0) $display("Test passed");
        else $display("Test failed");
        $finish;
    end

endmodule

// ==== sim.f ====
source/ntt_pkg.sv
source/mod_mult.sv
source/butterfly_lane.sv
source/writeback_merge.sv
source/ntt_butterfly_top.sv
tests/ntt_asserts.sv
tests/ntt_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = ntt_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
